//--- Makefile
VERILATOR  ?= verilator
TOP        ?= lsu_tb
RTL_TOP    ?= lsu_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
VFLAGS     ?= -Wno-fatal
JOBS       ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/axil_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module axil_master (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    req_valid,
	input  wire lsu_pkg::mem_req_t req,
	output logic                   busy,
	output lsu_pkg::axil_ar_t      ar,
	output logic                   arvalid,
	input  wire                    arready,
	input  wire lsu_pkg::axil_r_t  r,
	input  wire                    rvalid,
	output logic                   rready,
	output lsu_pkg::axil_aw_t      aw,
	output logic                   awvalid,
	input  wire                    awready,
	output lsu_pkg::axil_w_t       w,
	output logic                   wvalid,
	input  wire                    wready,
	input  wire lsu_pkg::axil_b_t  b,
	input  wire                    bvalid,
	output logic                   bready,
	output logic                   done_valid,
	output lsu_pkg::mem_req_t      done_req,
	output lsu_pkg::data_t         done_data,
	output lsu_pkg::resp_t         done_resp
);

	lsu_pkg::master_state_e state;
	lsu_pkg::mem_req_t      req_q;
	lsu_pkg::data_t         data_q;
	lsu_pkg::resp_t         resp_q;
	logic                   busy_q; // busy as the command saw it
	logic                   take;

	// commands strobed while busy never start
	assign take = (state == lsu_pkg::IDLE) && req_valid && !busy_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state  <= lsu_pkg::IDLE;
			busy   <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			busy_q <= busy; // decode is one cycle behind cmd_valid
			case (state)
				lsu_pkg::IDLE: begin
					if (take) begin
						busy <= 1'b1;
						if (req.misaligned)
							state <= lsu_pkg::DONE; // no bus traffic
						else if (req.is_store)
							state <= lsu_pkg::WRITE_REQ;
						else
							state <= lsu_pkg::READ_ADDR;
					end
				end
				lsu_pkg::READ_ADDR: begin
					if (arready)
						state <= lsu_pkg::READ_WAIT;
				end
				lsu_pkg::READ_WAIT: begin
					if (rvalid)
						state <= lsu_pkg::DONE; // rready is high here
				end
				lsu_pkg::WRITE_REQ: begin
					if (awready && wready) // aw and w go together
						state <= lsu_pkg::WRITE_WAIT;
				end
				lsu_pkg::WRITE_WAIT: begin
					if (bvalid)
						state <= lsu_pkg::DONE;
				end
				lsu_pkg::DONE: begin
					state <= lsu_pkg::IDLE;
					busy  <= 1'b0; // drops with res_valid
				end
				default: state <= lsu_pkg::IDLE;
			endcase
		end
	end

	// request copy plus captured read data and response
	always_ff @(posedge clk) begin
		if (take) begin
			req_q  <= req;
			data_q <= '0;
			resp_q <= `LSU_RESP_OKAY; // misaligned reports okay and the flag carries the error
		end
		if (state == lsu_pkg::READ_WAIT && rvalid) begin
			data_q <= r.data;
			resp_q <= r.resp;
		end
		if (state == lsu_pkg::WRITE_WAIT && bvalid)
			resp_q <= b.resp;
	end

	// channel payloads stay put while valid
	assign ar.addr = req_q.waddr;
	assign aw.addr = req_q.waddr;
	assign w.data  = req_q.wdata;
	assign w.strb  = req_q.strb;

	assign arvalid = (state == lsu_pkg::READ_ADDR);
	assign awvalid = (state == lsu_pkg::WRITE_REQ);
	assign wvalid  = (state == lsu_pkg::WRITE_REQ);
	assign rready  = (state == lsu_pkg::READ_WAIT);
	assign bready  = (state == lsu_pkg::WRITE_WAIT);

	assign done_valid = (state == lsu_pkg::DONE);
	assign done_req   = req_q;
	assign done_data  = data_q;
	assign done_resp  = resp_q;

endmodule

`default_nettype wire

//--- hdl/axil_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module axil_sram (
	input  wire                    clk,
	input  wire                    rst,
	input  wire lsu_pkg::axil_ar_t ar,
	input  wire                    arvalid,
	output logic                   arready,
	output lsu_pkg::axil_r_t       r,
	output logic                   rvalid,
	input  wire                    rready,
	input  wire lsu_pkg::axil_aw_t aw,
	input  wire                    awvalid,
	output logic                   awready,
	input  wire lsu_pkg::axil_w_t  w,
	input  wire                    wvalid,
	output logic                   wready,
	output lsu_pkg::axil_b_t       b,
	output logic                   bvalid,
	input  wire                    bready
);

	localparam int IDX_W = $clog2(`LSU_SRAM_WORDS);
	localparam int CNT_W = $clog2(`LSU_SRAM_DELAY + 1);

	lsu_pkg::data_t       mem [`LSU_SRAM_WORDS];
	lsu_pkg::sram_state_e state;
	logic                 rd_rdy_q;
	logic                 wr_rdy_q;
	logic                 wr_open;
	logic                 ar_fire;
	logic                 aw_fire;
	logic [CNT_W-1:0]     cnt;
	logic                 cnt_done;
	logic [IDX_W-1:0]     rd_idx;
	logic [IDX_W-1:0]     wr_idx;
	logic                 rd_ok;
	logic                 wr_ok;
	lsu_pkg::data_t       wr_data;
	lsu_pkg::strb_t       wr_strb;

	// word index below the depth
	function automatic logic in_range(input lsu_pkg::addr_t a);
		return {2'b00, a[`LSU_ADDR_W-1:2]} < `LSU_ADDR_W'(`LSU_SRAM_WORDS);
	endfunction

	assign arready = rd_rdy_q;
	assign wr_open = wr_rdy_q && !arvalid; // pending read goes first
	assign awready = wr_open;
	assign wready  = wr_open;

	assign ar_fire  = arvalid && rd_rdy_q;
	assign aw_fire  = awvalid && wvalid && wr_open;
	assign cnt_done = (cnt == CNT_W'(`LSU_SRAM_DELAY - 1));

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= lsu_pkg::LISTEN;
			rvalid   <= 1'b0;
			bvalid   <= 1'b0;
			rd_rdy_q <= 1'b1; // ready straight out of reset
			wr_rdy_q <= 1'b1;
			cnt      <= '0;
		end else begin
			case (state)
				lsu_pkg::LISTEN: begin
					if (ar_fire) begin
						state    <= lsu_pkg::FEED;
						rd_rdy_q <= 1'b0; // one access at a time
						wr_rdy_q <= 1'b0;
						cnt      <= '0;
					end else if (aw_fire) begin
						state    <= lsu_pkg::WRITE;
						rd_rdy_q <= 1'b0;
						wr_rdy_q <= 1'b0;
					end
				end
				lsu_pkg::FEED: begin
					if (cnt_done) begin
						state  <= lsu_pkg::WAIT_READ;
						rvalid <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1; // access delay
					end
				end
				lsu_pkg::WAIT_READ: begin
					if (rready) begin // rvalid held until taken
						state    <= lsu_pkg::LISTEN;
						rvalid   <= 1'b0;
						rd_rdy_q <= 1'b1;
						wr_rdy_q <= 1'b1;
					end
				end
				lsu_pkg::WRITE: begin
					state  <= lsu_pkg::WAIT_RESP;
					bvalid <= 1'b1; // memory updated this cycle
				end
				lsu_pkg::WAIT_RESP: begin
					if (bready) begin
						state    <= lsu_pkg::LISTEN;
						bvalid   <= 1'b0;
						rd_rdy_q <= 1'b1;
						wr_rdy_q <= 1'b1;
					end
				end
				default: state <= lsu_pkg::LISTEN;
			endcase
		end
	end

	// latched request and response payload
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rd_idx <= ar.addr[IDX_W+1:2];
			rd_ok  <= in_range(ar.addr);
		end
		if (aw_fire) begin
			wr_idx  <= aw.addr[IDX_W+1:2];
			wr_ok   <= in_range(aw.addr);
			wr_data <= w.data;
			wr_strb <= w.strb;
		end
		if (state == lsu_pkg::FEED && cnt_done) begin
			r.data <= rd_ok ? mem[rd_idx] : '0; // zero data out of range
			r.resp <= rd_ok ? `LSU_RESP_OKAY : `LSU_RESP_SLVERR;
		end
		if (state == lsu_pkg::WRITE)
			b.resp <= wr_ok ? `LSU_RESP_OKAY : `LSU_RESP_SLVERR;
	end

	// byte merge under strobes
	always_ff @(posedge clk) begin
		if (state == lsu_pkg::WRITE && wr_ok) begin
			for (int i = 0; i < `LSU_DATA_W/8; i++) begin
				if (wr_strb[i])
					mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_decode (
	input  wire               clk,
	input  wire               rst,
	input  wire               cmd_valid,
	input  wire lsu_pkg::mem_cmd_t cmd,
	output logic              req_valid,
	output lsu_pkg::mem_req_t req
);

	lsu_pkg::lane_t lane;
	lsu_pkg::strb_t strb;
	lsu_pkg::data_t lanes;
	logic           misaligned;

	assign lane = cmd.addr[1:0];

	// strobes and replicated store data by size
	always_comb begin
		case (cmd.size)
			`LSU_SIZE_B: begin
				strb  = lsu_pkg::strb_t'(4'b0001) << lane;
				lanes = {(`LSU_DATA_W/8){cmd.wdata[7:0]}}; // byte in every lane
			end
			`LSU_SIZE_H: begin
				strb  = lsu_pkg::strb_t'(4'b0011) << lane;
				lanes = {(`LSU_DATA_W/16){cmd.wdata[15:0]}};
			end
			default: begin // word, reserved size treated alike
				strb  = '1;
				lanes = cmd.wdata;
			end
		endcase
	end

	// halfword needs even address, word needs low pair zero
	assign misaligned = ((cmd.size == `LSU_SIZE_H) && lane[0]) ||
		((cmd.size != `LSU_SIZE_B) && (cmd.size != `LSU_SIZE_H) && (lane != 2'd0));

	always_ff @(posedge clk) begin
		if (!rst) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= cmd_valid; // one cycle behind the command
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			req.is_store   <= cmd.is_store;
			req.waddr      <= {cmd.addr[`LSU_ADDR_W-1:2], 2'b00};
			req.strb       <= strb;
			req.wdata      <= lanes;
			req.misaligned <= misaligned;
			req.size       <= cmd.size;
			req.is_signed  <= cmd.is_signed;
			req.lane       <= lane;
		end
	end

endmodule

`default_nettype wire

//--- hdl/lsu_pkg.sv
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

	typedef logic [`LSU_ADDR_W-1:0]   addr_t;
	typedef logic [`LSU_DATA_W-1:0]   data_t;
	typedef logic [`LSU_DATA_W/8-1:0] strb_t;
	typedef logic [1:0]               resp_t;
	typedef logic [1:0]               size_t;
	typedef logic [1:0]               err_t;
	typedef logic [1:0]               lane_t; // byte offset inside a word

	typedef struct packed {
		logic  is_store;
		size_t size;
		logic  is_signed;
		addr_t addr;
		data_t wdata;
	} mem_cmd_t;

	typedef struct packed {
		logic  is_store;
		addr_t waddr;     // word aligned
		strb_t strb;
		data_t wdata;     // already in its lanes
		logic  misaligned;
		size_t size;      // kept for the result stage
		logic  is_signed;
		lane_t lane;
	} mem_req_t;

	typedef struct packed {
		data_t data;
		err_t  err;
	} mem_res_t;

	typedef struct packed {addr_t addr;} axil_ar_t;
	typedef struct packed {data_t data; resp_t resp;} axil_r_t;
	typedef struct packed {addr_t addr;} axil_aw_t;
	typedef struct packed {data_t data; strb_t strb;} axil_w_t;
	typedef struct packed {resp_t resp;} axil_b_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_WAIT,
		WRITE_REQ,
		WRITE_WAIT,
		DONE
	} master_state_e;

	typedef enum logic [2:0] {
		LISTEN,
		FEED,
		WAIT_READ,
		WRITE,
		WAIT_RESP
	} sram_state_e;

endpackage

`default_nettype wire

//--- hdl/lsu_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_result (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    done_valid,
	input  wire lsu_pkg::mem_req_t done_req,
	input  wire lsu_pkg::data_t    done_data,
	input  wire lsu_pkg::resp_t    done_resp,
	output logic                   res_valid,
	output lsu_pkg::mem_res_t      res
);

	lsu_pkg::data_t shifted;
	lsu_pkg::data_t load_val;
	lsu_pkg::err_t  err;

	// addressed lane down to bit 0, then extend by size
	always_comb begin
		shifted = done_data >> {done_req.lane, 3'b000};
		case (done_req.size)
			`LSU_SIZE_B:
				load_val = {{(`LSU_DATA_W-8){done_req.is_signed & shifted[7]}}, shifted[7:0]};
			`LSU_SIZE_H:
				load_val = {{(`LSU_DATA_W-16){done_req.is_signed & shifted[15]}},
					shifted[15:0]};
			default:
				load_val = shifted; // full word, lane is zero
		endcase
	end

	// misaligned wins over a bus error
	always_comb begin
		if (done_req.misaligned)
			err = `LSU_ERR_MISALIGN;
		else if (done_resp != `LSU_RESP_OKAY)
			err = `LSU_ERR_BUS;
		else
			err = `LSU_ERR_NONE;
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= done_valid; // single cycle strobe
		end
	end

	always_ff @(posedge clk) begin
		if (done_valid) begin
			res.err  <= err;
			res.data <= (done_req.is_store || err != `LSU_ERR_NONE) ? '0 : load_val;
		end
	end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    cmd_valid,
	input  wire lsu_pkg::mem_cmd_t cmd,
	output logic                   busy,
	output logic                   res_valid,
	output lsu_pkg::mem_res_t      res
);

	logic              req_valid;
	lsu_pkg::mem_req_t req;

	// axi-lite between master and sram
	lsu_pkg::axil_ar_t ar;
	logic              arvalid, arready;
	lsu_pkg::axil_r_t  r;
	logic              rvalid, rready;
	lsu_pkg::axil_aw_t aw;
	logic              awvalid, awready;
	lsu_pkg::axil_w_t  w;
	logic              wvalid, wready;
	lsu_pkg::axil_b_t  b;
	logic              bvalid, bready;

	// master to result stage
	logic              done_valid;
	lsu_pkg::mem_req_t done_req;
	lsu_pkg::data_t    done_data;
	lsu_pkg::resp_t    done_resp;

	lsu_decode u_decode (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd(cmd),
		.req_valid(req_valid), .req(req)
	);

	axil_master u_master (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req(req), .busy(busy),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.done_valid(done_valid), .done_req(done_req),
		.done_data(done_data), .done_resp(done_resp)
	);

	axil_sram u_sram (
		.clk(clk), .rst(rst),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready)
	);

	lsu_result u_result (
		.clk(clk), .rst(rst),
		.done_valid(done_valid), .done_req(done_req),
		.done_data(done_data), .done_resp(done_resp),
		.res_valid(res_valid), .res(res)
	);

endmodule

`default_nettype wire

//--- include/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

`define LSU_ADDR_W      32
`define LSU_DATA_W      32
`define LSU_SRAM_WORDS  64 // word index at or past this is out of range
`define LSU_SRAM_DELAY  4  // ar accept to rvalid, in cycles

// access sizes
`define LSU_SIZE_B      2'd0
`define LSU_SIZE_H      2'd1
`define LSU_SIZE_W      2'd2

// axi responses
`define LSU_RESP_OKAY   2'd0
`define LSU_RESP_SLVERR 2'd2

// result error codes
`define LSU_ERR_NONE    2'd0
`define LSU_ERR_MISALIGN 2'd1
`define LSU_ERR_BUS     2'd2

`endif

//--- sim.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/axil_master.sv
hdl/axil_sram.sv
hdl/lsu_result.sv
hdl/lsu_top.sv
tests/lsu_tb.sv

//--- tests/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_tb;

	localparam int    CLK_PERIOD        = 40;
	localparam int    RESET_CYCLES      = 3;
	localparam int    IDLE_CYCLES       = 3;                  // quiet cycles checked after reset
	localparam int    CYCLES_PER_VECTOR = `LSU_SRAM_DELAY + 12;
	localparam string VECTOR_FILE       = "tests/lsu_vectors.txt";

	// one command and the result it should give
	typedef struct packed {
		lsu_pkg::mem_cmd_t cmd;
		lsu_pkg::mem_res_t res;
	} vector_t;

	logic              clk = 1'b0;
	logic              rst;
	logic              cmd_valid;
	lsu_pkg::mem_cmd_t cmd;
	logic              busy;
	logic              res_valid;
	lsu_pkg::mem_res_t res;

	vector_t vectors[$];
	logic    vectors_loaded = 1'b0; // starts the watchdog

	lsu_top dut0 (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.res_valid(res_valid),
		.res(res)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	// lines starting with # or empty are skipped
	task automatic read_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f_store, f_size, f_signed, f_addr, f_wdata, f_data, f_err;
		vector_t     v;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the vector file %s", VECTOR_FILE);
			abort_run();
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h", f_store, f_size, f_signed,
					f_addr, f_wdata, f_data, f_err);
				if (n != 7) begin
					$display("vector line has %0d fields instead of 7: %s", n, line);
					abort_run();
				end
				v.cmd.is_store  = f_store[0];
				v.cmd.size      = lsu_pkg::size_t'(f_size);
				v.cmd.is_signed = f_signed[0];
				v.cmd.addr      = lsu_pkg::addr_t'(f_addr);
				v.cmd.wdata     = lsu_pkg::data_t'(f_wdata);
				v.res.data      = lsu_pkg::data_t'(f_data);
				v.res.err       = lsu_pkg::err_t'(f_err);
				vectors.push_back(v);
			end
		end
		$fclose(fd);
		if (vectors.size() == 0) begin
			$display("the vector file holds no vectors");
			abort_run();
		end
	endtask

	// one command in, wait for its result strobe
	task automatic run_vector(input vector_t v, input int idx);
		logic saw_busy;
		saw_busy = 1'b0;
		while (busy)
			@(negedge clk); // no command while busy
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd       <= v.cmd;
		@(posedge clk);
		cmd_valid <= 1'b0;
		do begin
			@(negedge clk); // outputs settled here
			if (busy)
				saw_busy = 1'b1;
		end while (!res_valid);
		check_value($sformatf("vector %0d res.data", idx), res.data, v.res.data);
		check_value($sformatf("vector %0d res.err", idx), 32'(res.err), 32'(v.res.err));
		check_value($sformatf("vector %0d busy at res_valid", idx), 32'(busy), 32'd0);
		check_value($sformatf("vector %0d busy raised", idx), 32'(saw_busy), 32'd1);
	endtask

	initial begin
		rst       = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		read_vectors();
		vectors_loaded = 1'b1;
		$display("%0d vectors read", vectors.size());
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
		// quiet after reset, nothing strobed yet
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_value("busy after reset", 32'(busy), 32'd0);
			check_value("res_valid after reset", 32'(res_valid), 32'd0);
		end
		foreach (vectors[i])
			run_vector(vectors[i], i);
		$display("No errors");
		$finish;
	end

	// budget grows with the vector count
	initial begin : watchdog
		longint limit;
		wait (vectors_loaded);
		limit = longint'(vectors.size() * CYCLES_PER_VECTOR + RESET_CYCLES + IDLE_CYCLES + 8)
			* CLK_PERIOD;
		#(limit);
		$display("the run timed out after %0d ns without finishing the vectors", limit);
		abort_run();
	end

endmodule

`default_nettype wire

//--- tests/lsu_vectors.txt
# is_store size is_signed addr wdata exp_data exp_err, all hex
# size 0 byte, 1 halfword, 2 word; err 0 none, 1 misaligned, 2 bus error
1 2 0 00000000 deadbeef 00000000 0
0 2 0 00000000 00000000 deadbeef 0
1 2 0 00000004 11223344 00000000 0
1 0 0 00000005 123456aa 00000000 0
1 1 0 00000006 0000beef 00000000 0
0 2 0 00000004 00000000 beefaa44 0
0 0 1 00000005 00000000 ffffffaa 0
0 0 0 00000005 00000000 000000aa 0
0 1 1 00000006 00000000 ffffbeef 0
0 1 0 00000006 00000000 0000beef 0
0 0 1 00000004 00000000 00000044 0
0 1 1 00000004 00000000 ffffaa44 0
1 2 0 00000008 80017f02 00000000 0
0 0 1 0000000b 00000000 ffffff80 0
0 0 1 0000000a 00000000 00000001 0
0 1 1 00000008 00000000 00007f02 0
0 1 1 0000000a 00000000 ffff8001 0
0 1 0 0000000a 00000000 00008001 0
1 1 0 00000005 00001234 00000000 1
1 2 0 00000006 cafef00d 00000000 1
0 1 1 00000003 00000000 00000000 1
0 2 0 00000002 00000000 00000000 1
0 2 0 00000004 00000000 beefaa44 0
1 2 0 00000100 55555555 00000000 2
0 2 0 00000100 00000000 00000000 2
0 0 0 00000ffc 00000000 00000000 2
0 1 1 00001002 00000000 00000000 2
0 2 0 00000101 00000000 00000000 1
1 2 0 000000fc 0a0b0c0d 00000000 0
0 2 0 000000fc 00000000 0a0b0c0d 0
0 0 0 000000ff 00000000 0000000a 0
0 2 0 00000000 00000000 deadbeef 0
